//--- Makefile
TOP := tb_fft_twiddle_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test passed" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- csd_twiddle_mult.sv
`timescale 1ns/1ps
`default_nettype none

module csd_twiddle_mult (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      bf_valid,
  input  fft_types_pkg::cplx_bfly_t bf_sample,
  output logic                      mul_valid,
  output fft_types_pkg::cplx_prod_t mul_sample
);
  import fft_types_pkg::*;
  import fft_twiddle_pkg::*;

  logic signed [prod_bits-1:0] mr;      // Real part, sign extended
  logic signed [prod_bits-1:0] mi;      // Imag part, sign extended
  logic signed [prod_bits-1:0] mr_c;    // Real part times the CSD constant
  logic signed [prod_bits-1:0] mi_c;    // Imag part times the CSD constant
  logic signed [prod_bits-1:0] res_re;
  logic signed [prod_bits-1:0] res_im;
  phase_t                      last_phase;
  logic                        last_seen;

  // Shift-and-add multiply by -363, one negative digit and four positive ones
  function automatic logic signed [prod_bits-1:0] csd_mul(
    input logic signed [prod_bits-1:0] x
  );
    logic signed [prod_bits-1:0] acc;
    acc = -(x <<< csd_shift_neg);
    for (int i = 0; i < csd_num_pos; i++) begin
      acc = acc + (x <<< csd_shift_pos[i]);
    end
    return acc;
  endfunction

  assign mr = bf_sample.re;
  assign mi = bf_sample.im;

  // Same constant on real and imag coefficient, so one product per part
  assign mr_c = csd_mul(mr);
  assign mi_c = csd_mul(mi);

  always_comb begin
    case (bf_sample.phase)
      ph_neg_j: begin
        // (a+jb)(-j) = b - ja
        res_re = mi <<< coeff_frac_bits;
        res_im = -(mr <<< coeff_frac_bits);
      end
      ph_w8_3: begin
        // c(1+j)(a+jb) = c(a-b) + jc(a+b)
        res_re = mr_c - mi_c;
        res_im = mr_c + mi_c;
      end
      default: begin
        res_re = mr <<< coeff_frac_bits;  // Unity
        res_im = mi <<< coeff_frac_bits;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mul_valid <= 1'b0;
      last_seen <= 1'b0;
    end else begin
      mul_valid <= bf_valid;
      if (bf_valid) begin
        last_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bf_valid) begin
      mul_sample.re <= res_re;
      mul_sample.im <= res_im;
      last_phase    <= bf_sample.phase;  // Only for the ordering check
    end
  end

  // Phase tags from the butterfly step by one between accepted items
  assert property (@(posedge clk) disable iff (rst)
    (bf_valid && last_seen) |-> bf_sample.phase == phase_t'(last_phase + 2'd1))
    else $error("twiddle phase out of sequence");

endmodule

`default_nettype wire

//--- fft_twiddle_pkg.sv
`default_nettype none

package fft_twiddle_pkg;

  // Twiddle phase, counts accepted items modulo 4
  typedef logic [1:0] phase_t;

  // Phases 0 and 2 are plain unity scaling
  localparam phase_t ph_neg_j = 2'd1;  // Rotate by -j
  localparam phase_t ph_w8_3  = 2'd3;  // CSD constant times (1+j)

  // CSD digits of -363/512, i.e. -2^9 + 2^7 + 2^4 + 2^2 + 2^0
  localparam int csd_shift_neg = 9;
  localparam int csd_num_pos   = 4;
  localparam int csd_shift_pos [csd_num_pos] = '{7, 4, 2, 0};

  // Coefficients carry 9 fractional bits
  localparam int coeff_frac_bits = 9;

  // Half an LSB of the output, added before the shift
  localparam int round_half = 1 << (coeff_frac_bits - 1);

endpackage

`default_nettype wire

//--- fft_twiddle_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_twiddle_stage_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  fft_types_pkg::cplx_in_t  in_sample,
  output logic                     out_valid,
  output fft_types_pkg::cplx_out_t out_sample
);
  import fft_types_pkg::*;

  logic       bf_valid;
  cplx_bfly_t bf_sample;    // Butterfly result with phase
  logic       mul_valid;
  cplx_prod_t mul_sample;   // Full width product

  // SDF butterfly, delay of two samples
  sdf_butterfly u_bfly (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_sample (in_sample),
    .bf_valid  (bf_valid),
    .bf_sample (bf_sample)
  );

  csd_twiddle_mult u_twiddle (
    .clk        (clk),
    .rst        (rst),
    .bf_valid   (bf_valid),
    .bf_sample  (bf_sample),
    .mul_valid  (mul_valid),
    .mul_sample (mul_sample)
  );

  // Back to butterfly width
  round_saturate u_round (
    .clk        (clk),
    .rst        (rst),
    .mul_valid  (mul_valid),
    .mul_sample (mul_sample),
    .out_valid  (out_valid),
    .out_sample (out_sample)
  );

endmodule

`default_nettype wire

//--- fft_types_pkg.sv
`default_nettype none

package fft_types_pkg;

  // Sample widths per real or imaginary part
  localparam int sample_bits = 12;               // Input samples
  localparam int bfly_bits   = sample_bits + 1;  // One growth bit from the butterfly
  localparam int coeff_bits  = 11;               // Twiddle coefficient format

  // Full product width, including the CSD real/imag combination bit
  localparam int prod_bits = bfly_bits + coeff_bits + 1;

  // Stream input, re in the upper half
  typedef struct packed {
    logic signed [sample_bits-1:0] re;
    logic signed [sample_bits-1:0] im;
  } cplx_in_t;

  // Butterfly result with its twiddle phase tag
  typedef struct packed {
    logic signed [bfly_bits-1:0] re;
    logic signed [bfly_bits-1:0] im;
    fft_twiddle_pkg::phase_t     phase;
  } cplx_bfly_t;

  // Twiddle product before rounding
  typedef struct packed {
    logic signed [prod_bits-1:0] re;
    logic signed [prod_bits-1:0] im;
  } cplx_prod_t;

  // Rounded and clamped output, also the width of the butterfly delay line
  typedef struct packed {
    logic signed [bfly_bits-1:0] re;
    logic signed [bfly_bits-1:0] im;
  } cplx_out_t;

endpackage

`default_nettype wire

//--- round_saturate.sv
`timescale 1ns/1ps
`default_nettype none

module round_saturate (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mul_valid,
  input  fft_types_pkg::cplx_prod_t mul_sample,
  output logic                      out_valid,
  output fft_types_pkg::cplx_out_t  out_sample
);
  import fft_types_pkg::*;
  import fft_twiddle_pkg::*;

  // Output range limits at product width
  localparam logic signed [prod_bits-1:0] out_max = prod_bits'((1 << (bfly_bits - 1)) - 1);
  localparam logic signed [prod_bits-1:0] out_min = -out_max - 1;

  logic signed [bfly_bits-1:0] sat_re;
  logic signed [bfly_bits-1:0] sat_im;

  // Round half up, drop the coefficient fraction, clamp
  function automatic logic signed [bfly_bits-1:0] rnd_sat(
    input logic signed [prod_bits-1:0] x
  );
    logic signed [prod_bits-1:0] shifted;
    shifted = (x + prod_bits'(round_half)) >>> coeff_frac_bits;
    if (shifted > out_max) begin
      return out_max[bfly_bits-1:0];
    end else if (shifted < out_min) begin
      return out_min[bfly_bits-1:0];
    end
    return shifted[bfly_bits-1:0];
  endfunction

  assign sat_re = rnd_sat(mul_sample.re);
  assign sat_im = rnd_sat(mul_sample.im);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= mul_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_valid) begin
      out_sample.re <= sat_re;
      out_sample.im <= sat_im;
    end
  end

  // Any X here came through the whole pipeline
  assert property (@(posedge clk) disable iff (rst) out_valid |-> !$isunknown(out_sample))
    else $error("unknown bits on out_sample while out_valid");

endmodule

`default_nettype wire

//--- sdf_butterfly.sv
`timescale 1ns/1ps
`default_nettype none

module sdf_butterfly (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  fft_types_pkg::cplx_in_t   in_sample,
  output logic                      bf_valid,
  output fft_types_pkg::cplx_bfly_t bf_sample
);
  import fft_types_pkg::*;
  import fft_twiddle_pkg::*;

  phase_t    cnt;          // Accepted samples modulo 4
  logic      frame_done;   // Set once a whole frame has gone in
  cplx_out_t dly [2];      // Feedback delay with dly[1] the oldest entry
  cplx_out_t in_ext;
  cplx_out_t sum;
  cplx_out_t diff;
  logic      second_half;

  // Signed fields sign extend here
  assign in_ext.re = in_sample.re;
  assign in_ext.im = in_sample.im;

  assign second_half = cnt[1];

  // Butterfly on the head of the delay line and the new sample
  assign sum.re  = dly[1].re + in_ext.re;
  assign sum.im  = dly[1].im + in_ext.im;
  assign diff.re = dly[1].re - in_ext.re;
  assign diff.im = dly[1].im - in_ext.im;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt        <= '0;
      frame_done <= 1'b0;
      dly[0]     <= '0;
      dly[1]     <= '0;
      bf_valid   <= 1'b0;
    end else begin
      // First half outputs stored differences once frame one is in
      bf_valid <= in_valid && (second_half || frame_done);
      if (in_valid) begin
        cnt <= cnt + 2'd1;
        if (cnt == 2'd3) begin
          frame_done <= 1'b1;
        end
        dly[1] <= dly[0];
        dly[0] <= second_half ? diff : in_ext;  // Keep difference for next frame
      end
    end
  end

  // Payload loads only on accepted samples
  always_ff @(posedge clk) begin
    if (in_valid) begin
      if (second_half) begin
        bf_sample.re <= sum.re;
        bf_sample.im <= sum.im;
      end else begin
        bf_sample.re <= dly[1].re;  // Previous frame's difference
        bf_sample.im <= dly[1].im;
      end
      // Sums get phases 0 and 1 and differences 2 and 3
      bf_sample.phase <= cnt + 2'd2;
    end
  end

  // Differences leave only after a whole frame has been stored
  assert property (@(posedge clk) disable iff (rst)
    (bf_valid && bf_sample.phase[1]) |-> frame_done)
    else $error("difference output before the first frame was stored");

endmodule

`default_nettype wire

//--- sources.f
fft_twiddle_pkg.sv
fft_types_pkg.sv
sdf_butterfly.sv
csd_twiddle_mult.sv
round_saturate.sv
fft_twiddle_stage_top.sv
tb_fft_checker.sv
tb_fft_twiddle_stage.sv

//--- tb_fft_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fft_checker (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  fft_types_pkg::cplx_in_t  in_sample,
  input  logic [79:0]              test_name,
  input  logic                     expect_sat,
  input  logic                     out_valid,
  input  fft_types_pkg::cplx_out_t out_sample,
  output int                       error_count,
  output int                       match_count,
  output int                       pending_count
);
  import fft_types_pkg::*;
  import fft_twiddle_pkg::*;

  localparam int scale  = 1 << coeff_frac_bits;
  localparam int out_hi = (1 << (bfly_bits - 1)) - 1;
  localparam int out_lo = -(1 << (bfly_bits - 1));

  int          csd_coeff;      // About W8^3 times 512
  int          exp_re [$];
  int          exp_im [$];
  int          exp_cyc [$];    // Cycle the output is due
  int          exp_phase [$];
  logic [79:0] exp_name [$];
  int          x_re [2];       // First half of the current frame
  int          x_im [2];
  int          pend_re [2];    // Differences held for the next frame
  int          pend_im [2];
  logic [79:0] pend_name;
  logic        pend_sat;
  logic        have_prev;
  int          cnt;
  int          cyc;

  initial begin
    csd_coeff = -(1 << csd_shift_neg);
    for (int i = 0; i < csd_num_pos; i++) begin
      csd_coeff += 1 << csd_shift_pos[i];
    end
  end

  function automatic int round_down(input int x);
    return (x + round_half) >>> coeff_frac_bits;
  endfunction

  function automatic int clamp(input int x);
    if (x > out_hi) begin
      return out_hi;
    end else if (x < out_lo) begin
      return out_lo;
    end
    return x;
  endfunction

  // Twiddle, round and clamp one butterfly result, then queue it
  task automatic push_expected(input int a, input int b, input int ph,
                               input logic [79:0] name, input logic sat);
    int tre;
    int tim;
    case (ph)
      1: begin
        tre = b * scale;
        tim = -a * scale;
      end
      3: begin
        tre = csd_coeff * (a - b);
        tim = csd_coeff * (a + b);
      end
      default: begin
        tre = a * scale;
        tim = b * scale;
      end
    endcase
    if (sat && ph == 3 && clamp(round_down(tre)) == round_down(tre)
        && clamp(round_down(tim)) == round_down(tim)) begin
      error_count++;
      $display("Saturation row %0s does not reach the output limit", name);
    end
    exp_re.push_back(clamp(round_down(tre)));
    exp_im.push_back(clamp(round_down(tim)));
    exp_cyc.push_back(cyc + 3);
    exp_phase.push_back(ph);
    exp_name.push_back(name);
  endtask

  task automatic check_output();
    int act_re;
    int act_im;
    int due;
    if (out_valid) begin
      act_re = out_sample.re;
      act_im = out_sample.im;
      if (exp_re.size() == 0) begin
        error_count++;
        $display("Unexpected output (%0d, %0d) at cycle %0d", act_re, act_im, cyc);
      end else begin
        due = exp_cyc.pop_front();
        if (due != cyc) begin
          error_count++;
          $display("Output for %0s came at cycle %0d, due at %0d", exp_name[0], cyc, due);
        end
        if (act_re != exp_re[0] || act_im != exp_im[0]) begin
          error_count++;
          $display("ERROR %0s phase %0d: expected (%0d, %0d) actual (%0d, %0d)", exp_name[0],
                   exp_phase[0], exp_re[0], exp_im[0], act_re, act_im);
        end else begin
          match_count++;
        end
        void'(exp_re.pop_front());
        void'(exp_im.pop_front());
        void'(exp_phase.pop_front());
        void'(exp_name.pop_front());
      end
    end else if (exp_cyc.size() != 0 && exp_cyc[0] <= cyc) begin
      error_count++;
      $display("No output for %0s at cycle %0d", exp_name[0], exp_cyc[0]);
      void'(exp_re.pop_front());
      void'(exp_im.pop_front());
      void'(exp_cyc.pop_front());
      void'(exp_phase.pop_front());
      void'(exp_name.pop_front());
    end
  endtask

  // SDF rule, per accepted sample
  task automatic model_input();
    int a;
    int b;
    a = in_sample.re;
    b = in_sample.im;
    if (cnt < 2) begin
      if (have_prev) begin
        push_expected(pend_re[cnt], pend_im[cnt], cnt + 2, pend_name, pend_sat);
      end
      x_re[cnt] = a;
      x_im[cnt] = b;
    end else begin
      push_expected(x_re[cnt-2] + a, x_im[cnt-2] + b, cnt - 2, test_name, expect_sat);
      pend_re[cnt-2] = x_re[cnt-2] - a;
      pend_im[cnt-2] = x_im[cnt-2] - b;
      pend_name = test_name;
      pend_sat  = expect_sat;
      have_prev = (cnt == 3) ? 1'b1 : have_prev;
    end
    cnt = (cnt + 1) % 4;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      exp_re.delete();
      exp_im.delete();
      exp_cyc.delete();
      exp_phase.delete();
      exp_name.delete();
      cnt         = 0;
      cyc         = 0;
      have_prev   = 1'b0;
      pend_sat    = 1'b0;
      pend_name   = '0;
      error_count = 0;
      match_count = 0;
    end else begin
      cyc++;
      check_output();
      if (in_valid) begin
        model_input();
      end
    end
    pending_count = exp_re.size();
  end

endmodule

`default_nettype wire

//--- tb_fft_twiddle_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fft_twiddle_stage;
  import fft_types_pkg::*;

  localparam int num_frames  = 8;
  localparam int drain_limit = 40;  // Cycles allowed to empty the pipeline

  // One row of the stimulus table
  typedef struct packed {
    logic [79:0]    name;
    logic           expect_sat;      // Phase 3 result must clamp
    cplx_in_t [3:0] smp;
  } frame_t;

  logic        clk;
  logic        rst;
  logic        in_valid;
  cplx_in_t    in_sample;
  logic        out_valid;
  cplx_out_t   out_sample;
  logic [79:0] cur_name;
  logic        cur_sat;
  int          error_count;
  int          match_count;
  int          pending_count;
  frame_t      frames [num_frames];

  always #10 clk = ~clk;

  fft_twiddle_stage_top uut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .out_valid  (out_valid),
    .out_sample (out_sample)
  );

  tb_fft_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_sample     (in_sample),
    .test_name     (cur_name),
    .expect_sat    (cur_sat),
    .out_valid     (out_valid),
    .out_sample    (out_sample),
    .error_count   (error_count),
    .match_count   (match_count),
    .pending_count (pending_count)
  );

  function automatic cplx_in_t cplx(input int re, input int im);
    cplx_in_t c;
    c.re = sample_bits'(re);
    c.im = sample_bits'(im);
    return c;
  endfunction

  function automatic frame_t make_frame(input logic [79:0] name, input logic sat,
                                        input cplx_in_t c0, input cplx_in_t c1,
                                        input cplx_in_t c2, input cplx_in_t c3);
    frame_t f;
    f.name       = name;
    f.expect_sat = sat;
    f.smp[0]     = c0;
    f.smp[1]     = c1;
    f.smp[2]     = c2;
    f.smp[3]     = c3;
    return f;
  endfunction

  task automatic load_table();
    frames[0] = make_frame("impulse", 1'b0,
                           cplx(100, 0), cplx(0, 0), cplx(0, 0), cplx(0, 0));
    frames[1] = make_frame("ramp", 1'b0,
                           cplx(1, 2), cplx(3, 4), cplx(5, 6), cplx(7, 8));
    frames[2] = make_frame("mixed", 1'b0,
                           cplx(-500, 300), cplx(250, -125), cplx(-1000, -1000), cplx(37, -41));
    frames[3] = make_frame("rounding", 1'b0,
                           cplx(3, -5), cplx(-7, 1), cplx(1, 2), cplx(-2, 3));
    // Full-scale differences, clamp low then high
    frames[4] = make_frame("sat_neg", 1'b1,
                           cplx(2047, -2048), cplx(2047, -2048), cplx(-2048, 2047),
                           cplx(-2048, 2047));
    frames[5] = make_frame("sat_pos", 1'b1,
                           cplx(0, 0), cplx(-2048, 2047), cplx(0, 0), cplx(2047, -2048));
    frames[6] = make_frame("full_pos", 1'b0,
                           cplx(2047, 2047), cplx(2047, 2047), cplx(2047, 2047), cplx(2047, 2047));
    frames[7] = make_frame("flush", 1'b0,   // Releases the last differences
                           cplx(0, 0), cplx(0, 0), cplx(0, 0), cplx(0, 0));
  endtask

  initial begin
    int unsigned seed_sink;
    int          gap;
    int          wait_cycles;
    clk       = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_sample = '0;
    cur_name  = '0;
    cur_sat   = 1'b0;
    seed_sink = $urandom(32'h0ca1_b4ea);
    load_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int f = 0; f < num_frames; f++) begin
      for (int k = 0; k < 4; k++) begin
        gap = int'($urandom % 3);
        for (int g = 0; g < gap; g++) begin  // Idle gap
          @(negedge clk);
          in_valid = 1'b0;
        end
        @(negedge clk);
        in_valid  = 1'b1;
        in_sample = frames[f].smp[k];
        cur_name  = frames[f].name;
        cur_sat   = frames[f].expect_sat;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;

    wait_cycles = 0;
    while (pending_count != 0 && wait_cycles < drain_limit) begin
      @(negedge clk);
      wait_cycles++;
    end
    for (int s = 0; s < 5; s++) begin  // Catch stray outputs
      @(negedge clk);
    end

    if (pending_count != 0) begin
      $display("Timeout: %0d expected outputs never appeared", pending_count);
    end
    $display("Summary: %0d matched, %0d errors, %0d unmatched",
             match_count, error_count, pending_count);
    if (error_count == 0 && pending_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
